//--- rtl/mmu_macros.svh
`ifndef MMU_MACROS_SVH
`define MMU_MACROS_SVH

// Address and store data widths
`define MMU_ADDR_SIZE 32
`define MMU_WORD_SIZE 32

// One refill line is four words
`define MMU_LINE_SIZE 128

// Low address bits below a line
`define MMU_BYTE_OFFSET 4

// Lanes per cache and the width of a lane index
`define MMU_NUM_LANES 4
`define MMU_LANE_IDX 2

`endif

//--- rtl/mmu_pkg.sv
package mmu_pkg;

    // Refill arbiter states
    typedef enum logic [2:0] {
        IDLE,
        DC_REQ,
        DC_WAIT,
        IC_REQ,
        IC_WAIT
    } mmu_state_e;

    // Owner of the outstanding line read
    typedef enum logic [1:0] {
        REQ_NONE,
        REQ_DC,
        REQ_IC
    } requester_e;

endpackage

//--- rtl/mem_pkg.sv
package mem_pkg;

    // Width of a store sent to main memory
    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } store_type_e;

endpackage

//--- rtl/miss_capture.sv
`timescale 1ns/1ps
`include "mmu_macros.svh"

module miss_capture (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      miss_i,
    input  logic [`MMU_ADDR_SIZE-1:0] addr_i,
    input  logic                      done_i,
    output logic                      pending_o,
    output logic [`MMU_ADDR_SIZE-1:0] line_addr_o
);

    logic take_miss;

    // A second pulse while pending would overwrite the address in flight
    assign take_miss = miss_i && !pending_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pending_o <= 1'b0;
        end else if (done_i) begin
            pending_o <= 1'b0;
        end else if (take_miss) begin
            pending_o <= 1'b1;
        end
    end

    // Line aligned address
    always_ff @(posedge clk_i) begin
        if (take_miss) begin
            line_addr_o <= {addr_i[`MMU_ADDR_SIZE-1:`MMU_BYTE_OFFSET],
                            {`MMU_BYTE_OFFSET{1'b0}}};
        end
    end

    // Cache stays stalled until its refill has been delivered
    a_no_miss_while_pending: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        pending_o |-> !miss_i
    );

endmodule

//--- rtl/refill_arbiter.sv
`timescale 1ns/1ps
`include "mmu_macros.svh"

module refill_arbiter
    import mmu_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      dc_pending_i,
    input  logic                      ic_pending_i,
    input  logic [`MMU_ADDR_SIZE-1:0] dc_line_addr_i,
    input  logic [`MMU_ADDR_SIZE-1:0] ic_line_addr_i,
    input  logic                      mm_data_rdy_i,
    output logic                      mm_rd_req_o,
    output logic [`MMU_ADDR_SIZE-1:0] mm_addr_o,
    output requester_e                owner_o
);

    mmu_state_e state_q;
    mmu_state_e state_d;
    requester_e served_q;
    logic       dc_ready;
    logic       ic_ready;

    // Pending of the cache just served is still high until its done pulse
    assign dc_ready = dc_pending_i && (served_q != REQ_DC);
    assign ic_ready = ic_pending_i && (served_q != REQ_IC);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (dc_ready) begin
                    state_d = DC_REQ;
                end else if (ic_ready) begin
                    state_d = IC_REQ;
                end
            end
            DC_REQ: state_d = DC_WAIT;
            IC_REQ: state_d = IC_WAIT;
            // Hand over to the other cache when it waits
            DC_WAIT: begin
                if (mm_data_rdy_i) begin
                    state_d = ic_ready ? IC_REQ : IDLE;
                end
            end
            IC_WAIT: begin
                if (mm_data_rdy_i) begin
                    state_d = dc_ready ? DC_REQ : IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_comb begin
        case (state_q)
            DC_WAIT: owner_o = REQ_DC;
            IC_WAIT: owner_o = REQ_IC;
            default: owner_o = REQ_NONE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            served_q    <= REQ_NONE;
            mm_rd_req_o <= 1'b0;
        end else begin
            state_q     <= state_d;
            served_q    <= mm_data_rdy_i ? owner_o : REQ_NONE;
            mm_rd_req_o <= (state_d == DC_REQ) || (state_d == IC_REQ);
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_d == DC_REQ) begin
            mm_addr_o <= dc_line_addr_i;
        end else if (state_d == IC_REQ) begin
            mm_addr_o <= ic_line_addr_i;
        end
    end

    a_single_req_pulse: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        mm_rd_req_o |=> !mm_rd_req_o
    );

    // Memory answers only a read that was issued
    a_rdy_in_wait: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        mm_data_rdy_i |-> (state_q == DC_WAIT || state_q == IC_WAIT)
    );

endmodule

//--- rtl/lru_tracker.sv
`timescale 1ns/1ps
`include "mmu_macros.svh"

module lru_tracker (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     access_i,
    input  logic [`MMU_LANE_IDX-1:0] hit_lane_i,
    input  logic                     refill_i,
    input  logic [`MMU_LANE_IDX-1:0] refill_lane_i,
    output logic [`MMU_LANE_IDX-1:0] victim_o
);

    localparam int N     = `MMU_NUM_LANES;
    localparam int LRU_W = N * (N - 1) / 2;

    // Bit for pair (i, j) with i < j is set when lane i is newer than lane j
    logic [LRU_W-1:0]         order_q;
    logic [LRU_W-1:0]         order_d;
    logic                     touch;
    logic [`MMU_LANE_IDX-1:0] lane;
    logic                     oldest;

    function automatic int pair_idx(input int i, input int j);
        return i * (2 * N - i - 1) / 2 + (j - i - 1);
    endfunction

    assign touch = access_i || refill_i;
    assign lane  = access_i ? hit_lane_i : refill_lane_i;

    always_comb begin
        order_d = order_q;
        for (int i = 0; i < N - 1; i++) begin
            for (int j = i + 1; j < N; j++) begin
                if (lane == `MMU_LANE_IDX'(i)) begin
                    order_d[pair_idx(i, j)] = 1'b1;
                end else if (lane == `MMU_LANE_IDX'(j)) begin
                    order_d[pair_idx(i, j)] = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            order_q <= '0;
        end else if (touch) begin
            order_q <= order_d;
        end
    end

    // Oldest lane is older than every other lane
    always_comb begin
        victim_o = '0;
        for (int v = 0; v < N; v++) begin
            oldest = 1'b1;
            for (int k = 0; k < N; k++) begin
                if (k < v) oldest = oldest && order_q[pair_idx(k, v)];
                if (k > v) oldest = oldest && !order_q[pair_idx(v, k)];
            end
            if (oldest) victim_o = `MMU_LANE_IDX'(v);
        end
    end

    a_no_hit_during_refill: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(access_i && refill_i)
    );

endmodule

//--- rtl/refill_response.sv
`timescale 1ns/1ps
`include "mmu_macros.svh"

module refill_response
    import mmu_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      mm_data_rdy_i,
    input  logic [`MMU_LINE_SIZE-1:0] mm_data_i,
    input  requester_e                owner_i,
    input  logic [`MMU_LANE_IDX-1:0]  dc_victim_i,
    input  logic [`MMU_LANE_IDX-1:0]  ic_victim_i,
    output logic                      dc_rdy_o,
    output logic                      ic_rdy_o,
    output logic [`MMU_LINE_SIZE-1:0] dc_data_o,
    output logic [`MMU_LINE_SIZE-1:0] ic_data_o,
    output logic [`MMU_LANE_IDX-1:0]  dc_lru_index_o,
    output logic [`MMU_LANE_IDX-1:0]  ic_lru_index_o
);

    logic dc_hit;
    logic ic_hit;

    assign dc_hit = mm_data_rdy_i && (owner_i == REQ_DC);
    assign ic_hit = mm_data_rdy_i && (owner_i == REQ_IC);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            dc_rdy_o <= 1'b0;
            ic_rdy_o <= 1'b0;
        end else begin
            dc_rdy_o <= dc_hit;
            ic_rdy_o <= ic_hit;
        end
    end

    // Line and victim lane stay valid through the ready cycle
    always_ff @(posedge clk_i) begin
        if (dc_hit) begin
            dc_data_o      <= mm_data_i;
            dc_lru_index_o <= dc_victim_i;
        end
        if (ic_hit) begin
            ic_data_o      <= mm_data_i;
            ic_lru_index_o <= ic_victim_i;
        end
    end

    a_one_rdy_at_a_time: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(dc_rdy_o && ic_rdy_o)
    );

endmodule

//--- rtl/mmu_top.sv
`timescale 1ns/1ps
`include "mmu_macros.svh"

module mmu_top
    import mmu_pkg::*;
    import mem_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    // Data cache
    input  logic                      dc_miss_i,
    input  logic [`MMU_ADDR_SIZE-1:0] dc_addr_i,
    input  logic                      dc_access_i,
    input  logic [`MMU_LANE_IDX-1:0]  dc_hit_lane_i,
    input  logic                      dc_store_i,
    input  store_type_e               dc_store_type_i,
    input  logic [`MMU_WORD_SIZE-1:0] dc_store_data_i,
    output logic                      dc_rdy_o,
    output logic [`MMU_LINE_SIZE-1:0] dc_data_o,
    output logic [`MMU_LANE_IDX-1:0]  dc_lru_index_o,
    output logic [`MMU_ADDR_SIZE-1:0] dc_line_addr_o,
    // Instruction cache
    input  logic                      ic_miss_i,
    input  logic [`MMU_ADDR_SIZE-1:0] ic_addr_i,
    input  logic                      ic_access_i,
    input  logic [`MMU_LANE_IDX-1:0]  ic_hit_lane_i,
    output logic                      ic_rdy_o,
    output logic [`MMU_LINE_SIZE-1:0] ic_data_o,
    output logic [`MMU_LANE_IDX-1:0]  ic_lru_index_o,
    // Main memory
    input  logic                      mm_data_rdy_i,
    input  logic [`MMU_LINE_SIZE-1:0] mm_data_i,
    output logic                      mm_rd_req_o,
    output logic [`MMU_ADDR_SIZE-1:0] mm_addr_o,
    output logic                      mm_wr_req_o,
    output logic [`MMU_ADDR_SIZE-1:0] mm_wr_addr_o,
    output logic [`MMU_WORD_SIZE-1:0] mm_wr_data_o,
    output store_type_e               mm_wr_type_o
);

    logic                      dc_pending;
    logic                      ic_pending;
    logic [`MMU_ADDR_SIZE-1:0] ic_line_addr;
    logic [`MMU_LANE_IDX-1:0]  dc_victim;
    logic [`MMU_LANE_IDX-1:0]  ic_victim;
    requester_e                owner;

    // Stores bypass the refill path
    assign mm_wr_req_o  = dc_store_i;
    assign mm_wr_addr_o = dc_addr_i;
    assign mm_wr_data_o = dc_store_data_i;
    assign mm_wr_type_o = dc_store_type_i;

    miss_capture u_dc_miss (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .miss_i      (dc_miss_i),
        .addr_i      (dc_addr_i),
        .done_i      (dc_rdy_o),
        .pending_o   (dc_pending),
        .line_addr_o (dc_line_addr_o)
    );

    miss_capture u_ic_miss (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .miss_i      (ic_miss_i),
        .addr_i      (ic_addr_i),
        .done_i      (ic_rdy_o),
        .pending_o   (ic_pending),
        .line_addr_o (ic_line_addr)
    );

    refill_arbiter u_arbiter (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .dc_pending_i   (dc_pending),
        .ic_pending_i   (ic_pending),
        .dc_line_addr_i (dc_line_addr_o),
        .ic_line_addr_i (ic_line_addr),
        .mm_data_rdy_i  (mm_data_rdy_i),
        .mm_rd_req_o    (mm_rd_req_o),
        .mm_addr_o      (mm_addr_o),
        .owner_o        (owner)
    );

    // Each delivered line touches its own victim lane
    lru_tracker u_dc_lru (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .access_i      (dc_access_i),
        .hit_lane_i    (dc_hit_lane_i),
        .refill_i      (dc_rdy_o),
        .refill_lane_i (dc_lru_index_o),
        .victim_o      (dc_victim)
    );

    lru_tracker u_ic_lru (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .access_i      (ic_access_i),
        .hit_lane_i    (ic_hit_lane_i),
        .refill_i      (ic_rdy_o),
        .refill_lane_i (ic_lru_index_o),
        .victim_o      (ic_victim)
    );

    refill_response u_response (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .mm_data_rdy_i  (mm_data_rdy_i),
        .mm_data_i      (mm_data_i),
        .owner_i        (owner),
        .dc_victim_i    (dc_victim),
        .ic_victim_i    (ic_victim),
        .dc_rdy_o       (dc_rdy_o),
        .ic_rdy_o       (ic_rdy_o),
        .dc_data_o      (dc_data_o),
        .ic_data_o      (ic_data_o),
        .dc_lru_index_o (dc_lru_index_o),
        .ic_lru_index_o (ic_lru_index_o)
    );

endmodule

//--- sim/mmu_tb.sv
`timescale 1ns/1ps
`include "mmu_macros.svh"

module mmu_tb
    import mem_pkg::*;
();

    localparam int MAX_STEPS = 64;
    localparam int AW = `MMU_ADDR_SIZE;
    localparam int LW = `MMU_LINE_SIZE;

    logic clk, rst_n;
    logic dc_miss, dc_access, dc_store, ic_miss, ic_access;
    logic [AW-1:0] dc_addr, ic_addr, dc_line_addr, mm_addr, mm_wr_addr;
    logic [`MMU_LANE_IDX-1:0] dc_hit_lane, ic_hit_lane, dc_lru_index, ic_lru_index;
    logic [`MMU_WORD_SIZE-1:0] dc_store_data, mm_wr_data;
    logic [LW-1:0] dc_data, ic_data, mm_data;
    logic dc_rdy, ic_rdy, mm_data_rdy, mm_rd_req, mm_wr_req;
    store_type_e dc_store_type, mm_wr_type;
    // Memory data strobe one cycle back
    logic data_rdy_q;

    // One entry per data line
    logic [63:0] step_op [MAX_STEPS];
    logic [63:0] step_cache [MAX_STEPS];
    logic [AW-1:0] step_arg [MAX_STEPS];
    int step_lat [MAX_STEPS];
    int step_lane [MAX_STEPS];
    int num_steps, checks, errors;
    logic loaded;

    // Refills in flight, by issuing step
    int dc_steps[$], ic_steps[$], req_step[$], req_cache[$];
    // Reference lane order per cache, oldest first
    int ref_order [2][4];
    logic [31:0] mem_rng, store_rng;

    mmu_top UUT (
        .clk_i(clk), .rst_n_i(rst_n),
        .dc_miss_i(dc_miss), .dc_addr_i(dc_addr), .dc_access_i(dc_access),
        .dc_hit_lane_i(dc_hit_lane), .dc_store_i(dc_store), .dc_store_type_i(dc_store_type),
        .dc_store_data_i(dc_store_data), .dc_rdy_o(dc_rdy), .dc_data_o(dc_data),
        .dc_lru_index_o(dc_lru_index), .dc_line_addr_o(dc_line_addr),
        .ic_miss_i(ic_miss), .ic_addr_i(ic_addr), .ic_access_i(ic_access),
        .ic_hit_lane_i(ic_hit_lane), .ic_rdy_o(ic_rdy), .ic_data_o(ic_data),
        .ic_lru_index_o(ic_lru_index),
        .mm_data_rdy_i(mm_data_rdy), .mm_data_i(mm_data), .mm_rd_req_o(mm_rd_req),
        .mm_addr_o(mm_addr), .mm_wr_req_o(mm_wr_req), .mm_wr_addr_o(mm_wr_addr),
        .mm_wr_data_o(mm_wr_data), .mm_wr_type_o(mm_wr_type)
    );

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [AW-1:0] line_base(input logic [AW-1:0] addr);
        return addr & ~((AW'(1) << `MMU_BYTE_OFFSET) - AW'(1));
    endfunction

    // Memory returns four words counting up from the line address
    function automatic logic [LW-1:0] line_for(input logic [AW-1:0] addr);
        logic [AW-1:0] b;
        b = line_base(addr);
        return {b + 32'd3, b + 32'd2, b + 32'd1, b};
    endfunction

    function automatic logic [AW-1:0] miss_addr(input int c, input int s);
        if (c == 1 && step_cache[s] == "BOTH") return step_arg[s] + 32'h0001_0000;
        return step_arg[s];
    endfunction

    task automatic report_mismatch(input string what, input int s,
                                   input logic [LW-1:0] exp, input logic [LW-1:0] act);
        errors++;
        $display("error step %0d %s expected %0h actual %0h", s, what, exp, act);
    endtask

    task automatic touch_lane(input int c, input int lane);
        int p;
        p = 0;
        while (p < 3 && ref_order[c][p] != lane) p++;
        for (int k = p; k < 3; k++) ref_order[c][k] = ref_order[c][k + 1];
        ref_order[c][3] = lane;
    endtask

    task automatic check_refill(input int c, input logic [LW-1:0] data,
                                input logic [`MMU_LANE_IDX-1:0] lane);
        int s;
        int ref_lane;
        checks++;
        if ((c == 0 && dc_steps.size() == 0) || (c == 1 && ic_steps.size() == 0)) begin
            errors++;
            $display("ready strobe to cache %0d with no refill outstanding", c);
            return;
        end
        if (c == 0) s = dc_steps.pop_front();
        else s = ic_steps.pop_front();
        ref_lane = ref_order[c][0];
        if (data !== line_for(miss_addr(c, s)))
            report_mismatch(c == 0 ? "dc_data" : "ic_data", s, line_for(miss_addr(c, s)), data);
        checks++;
        if (lane !== ref_lane)
            report_mismatch(c == 0 ? "dc_lane" : "ic_lane", s, ref_lane, lane);
        // File lane covers the named cache only
        checks++;
        if (!(c == 1 && step_cache[s] == "BOTH") && lane !== step_lane[s])
            report_mismatch("file_lane", s, step_lane[s], lane);
        checks++;
        if (c == 0 && dc_line_addr !== line_base(miss_addr(0, s)))
            report_mismatch("dc_line_addr", s, line_base(miss_addr(0, s)), dc_line_addr);
        touch_lane(c, ref_lane);
    endtask

    task automatic tick();
        @(negedge clk);
        dc_miss = 1'b0;
        ic_miss = 1'b0;
        dc_access = 1'b0;
        ic_access = 1'b0;
        dc_store = 1'b0;
        if (dc_rdy || ic_rdy || data_rdy_q) begin
            checks++;
            if ((dc_rdy || ic_rdy) !== data_rdy_q) begin
                errors++;
                $display("ready strobe not exactly one cycle after the memory data strobe");
            end
        end
        if (dc_rdy) check_refill(0, dc_data, dc_lru_index);
        if (ic_rdy) check_refill(1, ic_data, ic_lru_index);
    endtask

    task automatic wait_free(input int c);
        while ((c == 0 && dc_steps.size() != 0) || (c == 1 && ic_steps.size() != 0)) tick();
    endtask

    task automatic run_step(input int s);
        logic [63:0] op;
        logic [63:0] cache;
        op = step_op[s];
        cache = step_cache[s];
        if (op == "MISS") begin
            if (cache != "IC") wait_free(0);
            if (cache != "DC") wait_free(1);
            tick();
            if (cache != "IC") begin
                dc_miss = 1'b1;
                dc_addr = miss_addr(0, s);
                dc_steps.push_back(s);
                req_step.push_back(s);
                req_cache.push_back(0);
            end
            if (cache != "DC") begin
                ic_miss = 1'b1;
                ic_addr = miss_addr(1, s);
                ic_steps.push_back(s);
                req_step.push_back(s);
                req_cache.push_back(1);
            end
        end else if (op == "HIT") begin
            wait_free(cache == "IC" ? 1 : 0);
            tick();
            if (cache == "IC") begin
                ic_access = 1'b1;
                ic_hit_lane = `MMU_LANE_IDX'(step_arg[s]);
            end else begin
                dc_access = 1'b1;
                dc_hit_lane = `MMU_LANE_IDX'(step_arg[s]);
            end
            touch_lane(cache == "IC" ? 1 : 0, int'(step_arg[s]));
        end else if (op == "STORE") begin
            wait_free(0);
            tick();
            store_rng = next_random(store_rng);
            dc_store = 1'b1;
            dc_addr = step_arg[s];
            dc_store_data = store_rng;
            dc_store_type = store_type_e'(step_lat[s]);
            #1;
            checks += 4;
            if (mm_wr_req !== 1'b1) begin
                errors++;
                $display("step %0d store did not raise the memory write request", s);
            end
            if (mm_wr_addr !== step_arg[s])
                report_mismatch("store_addr", s, step_arg[s], mm_wr_addr);
            if (mm_wr_data !== store_rng) report_mismatch("store_data", s, store_rng, mm_wr_data);
            if (mm_wr_type !== store_type_e'(step_lat[s]))
                report_mismatch("store_type", s, step_lat[s], mm_wr_type);
        end else if (op == "IDLE") begin
            wait_free(0);
            wait_free(1);
            repeat (int'(step_arg[s])) tick();
        end else begin
            errors++;
            $display("step %0d has an unknown operation", s);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        data_rdy_q <= mm_data_rdy;
    end

    // Main memory, one read at a time
    initial begin
        int s;
        int c;
        int cycles;
        mm_data_rdy = 1'b0;
        mm_data = '0;
        mem_rng = 32'ha43;
        forever begin
            @(negedge clk);
            mm_data_rdy = 1'b0;
            if (rst_n && mm_rd_req) begin
                checks++;
                if (req_step.size() == 0) begin
                    errors++;
                    $display("read request to %0h with no miss waiting", mm_addr);
                    cycles = 1;
                end else begin
                    s = req_step.pop_front();
                    c = req_cache.pop_front();
                    if (mm_addr !== line_base(miss_addr(c, s)))
                        report_mismatch("read_addr", s, line_base(miss_addr(c, s)), mm_addr);
                    cycles = step_lat[s];
                end
                if (cycles == 0) begin
                    mem_rng = next_random(mem_rng);
                    cycles = 1 + int'(mem_rng % 8);
                end
                repeat (cycles) @(negedge clk);
                mm_data = line_for(mm_addr);
                mm_data_rdy = 1'b1;
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (200 * num_steps + 64) @(posedge clk);
        $display("watchdog: run did not finish in %0d cycles", 200 * num_steps + 64);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int fd;
        int ch;
        int cnt;
        logic [63:0] op;
        rst_n = 1'b0;
        dc_miss = 1'b0;
        dc_addr = '0;
        dc_access = 1'b0;
        dc_hit_lane = '0;
        dc_store = 1'b0;
        dc_store_type = WORD;
        dc_store_data = '0;
        ic_miss = 1'b0;
        ic_addr = '0;
        ic_access = 1'b0;
        ic_hit_lane = '0;
        store_rng = 32'ha43;
        checks = 0;
        errors = 0;
        num_steps = 0;
        loaded = 1'b0;
        for (int c = 0; c < 2; c++)
            for (int k = 0; k < 4; k++) ref_order[c][k] = k;
        fd = $fopen("sim/mmu_testdata.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open sim/mmu_testdata.txt");
        end else begin
            while (num_steps < MAX_STEPS && $fscanf(fd, "%s", op) == 1) begin
                if (op == "#") begin
                    ch = $fgetc(fd);
                    while (ch != 10 && ch != -1) ch = $fgetc(fd);
                end else begin
                    cnt = $fscanf(fd, "%s %h %d %d", step_cache[num_steps],
                                  step_arg[num_steps], step_lat[num_steps],
                                  step_lane[num_steps]);
                    step_op[num_steps] = op;
                    if (cnt == 4) num_steps++;
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        for (int s = 0; s < num_steps; s++) run_step(s);
        wait_free(0);
        wait_free(1);
        repeat (4) tick();
        checks++;
        if (req_step.size() != 0) begin
            errors++;
            $display("%0d read requests never reached memory", req_step.size());
        end
        $display("mmu_tb finished: %0d steps, %0d checks, %0d errors", num_steps, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+rtl
rtl/mmu_pkg.sv
rtl/mem_pkg.sv
rtl/miss_capture.sv
rtl/refill_arbiter.sv
rtl/lru_tracker.sv
rtl/refill_response.sv
rtl/mmu_top.sv
sim/mmu_tb.sv

//--- sim/mmu_testdata.txt
# op cache addr_or_lane latency expected_lane  (BOTH sends addr to DC and addr+10000 to IC)
# A latency of 0 draws 1 to 8 cycles, and STORE holds its width code there (0 byte 1 half 2 word)
# Single data miss after reset
MISS  DC    00001234  3  0
IDLE  --    5         0  -1
# Both caches at once, data cache first
MISS  BOTH  00002008  2  1
IDLE  --    4         0  -1
HIT   DC    2         0  -1
HIT   IC    1         0  -1
# Overlapping misses alternate between the caches
MISS  DC    00003010  0  3
MISS  IC    00013020  0  2
MISS  DC    00003040  0  0
MISS  IC    00013050  0  3
MISS  DC    00003080  5  1
MISS  IC    000130a4  4  0
# Stores while an instruction refill is outstanding
STORE DC    00004444  2  -1
MISS  IC    00013100  6  1
STORE DC    00004446  1  -1
STORE DC    00004447  0  -1
# Hits reorder both trackers
HIT   DC    0         0  -1
HIT   DC    2         0  -1
HIT   IC    3         0  -1
MISS  BOTH  00005000  0  3
MISS  DC    00005010  0  1
MISS  IC    00015020  0  0
IDLE  --    8         0  -1
